// File: src/cpx_pkg.sv
`default_nettype none

package cpx_pkg;

  ////////////////////////////////////////
  // Widths and memory map
  ////////////////////////////////////////

  localparam int HALF_W    = 16;          // One signed component
  localparam int DATA_W    = 2 * HALF_W;  // {real, imag}, real on top
  localparam int ADDR_W    = 8;
  localparam int MEM_DEPTH = 1 << ADDR_W; // 256 words

  // First address written by a load burst
  localparam logic [ADDR_W-1:0] LOAD_BASE = '0;

  localparam int OP_W  = 8;
  localparam int IMM_W = 8;               // Signed immediate per half

  // RAM read path, latch plus output register
  localparam int RD_LAT = 2;

  ////////////////////////////////////////
  // Instruction word
  ////////////////////////////////////////

  typedef enum logic [OP_W-1:0] {
    OP_ADD = 8'h01, // a + b per component
    OP_SUB = 8'h02, // a - b per component
    OP_MUL = 8'h03, // Scaled complex product
    OP_SET = 8'h04  // Immediate to dst
  } opcode_e;

  // Opcode on top and dst at the bottom in both views
  typedef union packed {
    struct packed {
      opcode_e           opcode;
      logic [ADDR_W-1:0] src2;   // Operand b
      logic [ADDR_W-1:0] src1;   // Operand a
      logic [ADDR_W-1:0] dst;
    } alu;
    struct packed {
      opcode_e                  opcode;
      logic signed [IMM_W-1:0]  imm_re;
      logic signed [IMM_W-1:0]  imm_im;
      logic [ADDR_W-1:0]        dst;
    } imm;
  } inst_u;

endpackage

`default_nettype wire

// File: src/sdp_bram.sv
`timescale 1ns/1ns
`default_nettype none

// Simple dual port RAM, one clock
// Port a writes, port b reads with two cycles of latency
module sdp_bram #(
  parameter int RAM_WIDTH = 32,
  parameter int RAM_DEPTH = 256
) (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         wea,
  input  wire logic [$clog2(RAM_DEPTH)-1:0] addra,
  input  wire logic [RAM_WIDTH-1:0]         dina,
  input  wire logic                         enb,
  input  wire logic [$clog2(RAM_DEPTH)-1:0] addrb,
  output logic      [RAM_WIDTH-1:0]         doutb
);

  logic [RAM_WIDTH-1:0] mem [RAM_DEPTH]; // Storage array
  logic [RAM_WIDTH-1:0] ram_data;        // Read latch
  logic                 rd_done;         // Latch holds fresh data

  // Array write and read latch
  // Same address in one cycle returns the old word
  always_ff @(posedge clk) begin
    if (wea) begin
      mem[addra] <= dina;
    end
    if (enb) begin
      ram_data <= mem[addrb];
    end
  end

  // Output register, loads only after a real read
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_done <= 1'b0;
      doutb   <= '0;
    end else begin
      rd_done <= enb;
      if (rd_done) begin
        doutb <= ram_data; // Second cycle of the read
      end
    end
  end

endmodule

`default_nettype wire

// File: src/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

// Instruction decoder
// Turns an instruction strobe into RAM read addresses and an op word
// that reaches the ALU in the same cycle as the operands
module inst_decoder (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        inst_v,
  input  wire cpx_pkg::inst_u              inst,
  output logic      [cpx_pkg::ADDR_W-1:0]  raddr_a,
  output logic      [cpx_pkg::ADDR_W-1:0]  raddr_b,
  output logic                             rden,
  output logic                             op_v,
  output cpx_pkg::opcode_e                 op,
  output logic      [cpx_pkg::ADDR_W-1:0]  dst,
  output logic      [cpx_pkg::DATA_W-1:0]  imm
);

  import cpx_pkg::*;

  // Address register plus RAM latency
  localparam int DEPTH = RD_LAT + 1;

  logic [DATA_W-1:0] imm_ext;             // Immediate view, widened
  logic [DEPTH-1:0]  vld_pipe;            // Op valid per stage
  opcode_e           op_pipe  [DEPTH];
  logic [ADDR_W-1:0] dst_pipe [DEPTH];
  logic [DATA_W-1:0] imm_pipe [DEPTH];

  ////////////////////////////////////////
  // Immediate decode
  ////////////////////////////////////////

  // Each 8 bit immediate sign extended into its own half
  assign imm_ext = {
    {(HALF_W-IMM_W){inst.imm.imm_re[IMM_W-1]}}, inst.imm.imm_re,
    {(HALF_W-IMM_W){inst.imm.imm_im[IMM_W-1]}}, inst.imm.imm_im
  };

  ////////////////////////////////////////
  // Read addresses
  ////////////////////////////////////////

  // Source fields come from the alu view
  always_ff @(posedge clk) begin
    if (inst_v) begin
      raddr_a <= inst.alu.src1;
      raddr_b <= inst.alu.src2;
    end
  end

  // Latch enable needed one cycle after the address register
  assign rden = |vld_pipe[RD_LAT-1:0];

  ////////////////////////////////////////
  // Op delay line
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_pipe <= '0;
    end else begin
      vld_pipe[0] <= inst_v;
      for (int i = 1; i < DEPTH; i++) begin
        vld_pipe[i] <= vld_pipe[i-1];
      end
    end
  end

  // Payload follows the valid bit, no reset
  always_ff @(posedge clk) begin
    op_pipe[0]  <= inst.alu.opcode; // Same field in both views
    dst_pipe[0] <= inst.alu.dst;
    imm_pipe[0] <= imm_ext;
    for (int i = 1; i < DEPTH; i++) begin
      op_pipe[i]  <= op_pipe[i-1];
      dst_pipe[i] <= dst_pipe[i-1];
      imm_pipe[i] <= imm_pipe[i-1];
    end
  end

  // Last stage lines up with dout_a and dout_b
  assign op_v = vld_pipe[DEPTH-1];
  assign op   = op_pipe[DEPTH-1];
  assign dst  = dst_pipe[DEPTH-1];
  assign imm  = imm_pipe[DEPTH-1];

endmodule

`default_nettype wire

// File: src/data_mem.sv
`timescale 1ns/1ns
`default_nettype none

// Data memory with three reads and one write per cycle
// Three RAM copies share one write port so they always hold the same data
module data_mem (
  input  wire logic                        clk,
  input  wire logic                        rst,
  // Load burst
  input  wire logic                        load_v,
  input  wire logic      [cpx_pkg::DATA_W-1:0] load_data,
  // Operand reads from the decoder
  input  wire logic      [cpx_pkg::ADDR_W-1:0] raddr_a,
  input  wire logic      [cpx_pkg::ADDR_W-1:0] raddr_b,
  input  wire logic                        rden,
  // External readback
  input  wire logic                        rd_v,
  input  wire logic      [cpx_pkg::ADDR_W-1:0] rd_addr,
  // ALU write-back
  input  wire logic                        wb_v,
  input  wire logic      [cpx_pkg::ADDR_W-1:0] wb_addr,
  input  wire logic      [cpx_pkg::DATA_W-1:0] wb_data,
  output logic           [cpx_pkg::DATA_W-1:0] dout_a,
  output logic           [cpx_pkg::DATA_W-1:0] dout_b,
  output logic           [cpx_pkg::DATA_W-1:0] rd_data,
  output logic                             rd_data_v
);

  import cpx_pkg::*;

  logic [ADDR_W-1:0] load_cnt;   // Next burst address
  logic              we_r;       // Registered write enable
  logic [ADDR_W-1:0] waddr_r;
  logic [DATA_W-1:0] wdata_r;
  logic              rd_v_r;     // Port c request, address stage
  logic [ADDR_W-1:0] rd_addr_r;
  logic [RD_LAT-1:0] rd_pipe;    // rd_v_r through the RAM latency

  ////////////////////////////////////////
  // Write port
  ////////////////////////////////////////

  // Burst counter runs while load_v stays high
  always_ff @(posedge clk) begin
    if (rst) begin
      we_r     <= 1'b0;
      load_cnt <= LOAD_BASE;
    end else begin
      we_r <= load_v | wb_v;
      if (load_v) begin
        load_cnt <= load_cnt + 1'b1;
      end else begin
        load_cnt <= LOAD_BASE; // Gap rewinds the burst
      end
    end
  end

  // Load has priority, a colliding write-back is lost
  always_ff @(posedge clk) begin
    if (load_v) begin
      waddr_r <= load_cnt;
      wdata_r <= load_data;
    end else if (wb_v) begin
      waddr_r <= wb_addr;
      wdata_r <= wb_data;
    end
  end

  ////////////////////////////////////////
  // Port c readback
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    rd_addr_r <= rd_addr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_v_r  <= 1'b0;
      rd_pipe <= '0;
    end else begin
      rd_v_r     <= rd_v;
      rd_pipe[0] <= rd_v_r;
      for (int i = 1; i < RD_LAT; i++) begin
        rd_pipe[i] <= rd_pipe[i-1];
      end
    end
  end

  assign rd_data_v = rd_pipe[RD_LAT-1]; // Valid with the output register

  ////////////////////////////////////////
  // RAM copies
  ////////////////////////////////////////

  sdp_bram #(
    .RAM_WIDTH (DATA_W),
    .RAM_DEPTH (MEM_DEPTH)
  ) bram_a (
    .clk   (clk),
    .rst   (rst),
    .wea   (we_r),
    .addra (waddr_r),
    .dina  (wdata_r),
    .enb   (rden),
    .addrb (raddr_a),  // Operand a
    .doutb (dout_a)
  );

  sdp_bram #(
    .RAM_WIDTH (DATA_W),
    .RAM_DEPTH (MEM_DEPTH)
  ) bram_b (
    .clk   (clk),
    .rst   (rst),
    .wea   (we_r),
    .addra (waddr_r),
    .dina  (wdata_r),
    .enb   (rden),
    .addrb (raddr_b),  // Operand b
    .doutb (dout_b)
  );

  sdp_bram #(
    .RAM_WIDTH (DATA_W),
    .RAM_DEPTH (MEM_DEPTH)
  ) bram_c (
    .clk   (clk),
    .rst   (rst),
    .wea   (we_r),
    .addra (waddr_r),
    .dina  (wdata_r),
    .enb   (rd_v_r),
    .addrb (rd_addr_r), // External readback
    .doutb (rd_data)
  );

endmodule

`default_nettype wire

// File: src/cpx_alu.sv
`timescale 1ns/1ns
`default_nettype none

// One stage complex ALU
// Words are {real, imag}, 16 bit signed halves, sums wrap
module cpx_alu #(
  parameter int MUL_SHIFT = 15 // Fraction bits dropped after MUL
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        op_v,
  input  wire cpx_pkg::opcode_e            op,
  input  wire logic [cpx_pkg::ADDR_W-1:0]  dst,
  input  wire logic [cpx_pkg::DATA_W-1:0]  imm,
  input  wire logic [cpx_pkg::DATA_W-1:0]  src_a,
  input  wire logic [cpx_pkg::DATA_W-1:0]  src_b,
  output logic                             wb_v,
  output logic      [cpx_pkg::ADDR_W-1:0]  wb_addr,
  output logic      [cpx_pkg::DATA_W-1:0]  wb_data
);

  import cpx_pkg::*;

  // Components sign extended to product width
  logic signed [2*HALF_W-1:0] ar, ai, br, bi;
  logic signed [2*HALF_W-1:0] p_rr, p_ii, p_ri, p_ir; // Partial products
  logic signed [2*HALF_W:0]   m_re, m_im;             // One guard bit
  logic signed [2*HALF_W:0]   m_re_sh, m_im_sh;
  logic        [DATA_W-1:0]   result;

  assign ar = {{HALF_W{src_a[DATA_W-1]}}, src_a[DATA_W-1 -: HALF_W]};
  assign ai = {{HALF_W{src_a[HALF_W-1]}}, src_a[HALF_W-1:0]};
  assign br = {{HALF_W{src_b[DATA_W-1]}}, src_b[DATA_W-1 -: HALF_W]};
  assign bi = {{HALF_W{src_b[HALF_W-1]}}, src_b[HALF_W-1:0]};

  ////////////////////////////////////////
  // Complex multiply
  ////////////////////////////////////////

  assign p_rr = ar * br;
  assign p_ii = ai * bi;
  assign p_ri = ar * bi;
  assign p_ir = ai * br;

  // Full width difference and sum
  assign m_re = {p_rr[2*HALF_W-1], p_rr} - {p_ii[2*HALF_W-1], p_ii};
  assign m_im = {p_ri[2*HALF_W-1], p_ri} + {p_ir[2*HALF_W-1], p_ir};

  assign m_re_sh = m_re >>> MUL_SHIFT; // Arithmetic, keeps the sign
  assign m_im_sh = m_im >>> MUL_SHIFT;

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    result = '0;
    case (op)
      OP_ADD: result = {ar[HALF_W-1:0] + br[HALF_W-1:0],
                        ai[HALF_W-1:0] + bi[HALF_W-1:0]};
      OP_SUB: result = {ar[HALF_W-1:0] - br[HALF_W-1:0],
                        ai[HALF_W-1:0] - bi[HALF_W-1:0]};
      OP_MUL: result = {m_re_sh[HALF_W-1:0], m_im_sh[HALF_W-1:0]}; // Truncate
      OP_SET: result = imm;  // Already extended by the decoder
      default: result = '0;  // Unknown opcode writes zero
    endcase
  end

  // Write-back register
  always_ff @(posedge clk) begin
    if (rst) begin
      wb_v <= 1'b0;
    end else begin
      wb_v <= op_v; // One strobe per instruction
    end
  end

  always_ff @(posedge clk) begin
    if (op_v) begin
      wb_addr <= dst;
      wb_data <= result;
    end
  end

endmodule

`default_nettype wire

// File: src/cpx_core.sv
`timescale 1ns/1ns
`default_nettype none

// Complex arithmetic core
// Decoder feeds the memory read ports, memory feeds the ALU,
// ALU results go back into memory and out as a strobe
module cpx_core #(
  parameter int MUL_SHIFT = 15 // Q1.15 products
) (
  input  wire logic                        clk,
  input  wire logic                        rst,
  input  wire logic                        load_v,
  input  wire logic [cpx_pkg::DATA_W-1:0]  load_data,
  input  wire logic                        inst_v,
  input  wire cpx_pkg::inst_u              inst,
  input  wire logic                        rd_v,
  input  wire logic [cpx_pkg::ADDR_W-1:0]  rd_addr,
  output logic                             rd_data_v,
  output logic      [cpx_pkg::DATA_W-1:0]  rd_data,
  output logic                             wb_v,
  output logic      [cpx_pkg::ADDR_W-1:0]  wb_addr,
  output logic      [cpx_pkg::DATA_W-1:0]  wb_data
);

  import cpx_pkg::*;

  logic [ADDR_W-1:0] raddr_a, raddr_b; // Operand addresses
  logic              rden;
  logic              op_v;
  opcode_e           op;
  logic [ADDR_W-1:0] dst;
  logic [DATA_W-1:0] imm;
  logic [DATA_W-1:0] dout_a, dout_b;   // Operands, RD_LAT after the addresses

  inst_decoder u_dec (
    .clk     (clk),
    .rst     (rst),
    .inst_v  (inst_v),
    .inst    (inst),
    .raddr_a (raddr_a),
    .raddr_b (raddr_b),
    .rden    (rden),
    .op_v    (op_v),
    .op      (op),
    .dst     (dst),
    .imm     (imm)
  );

  data_mem u_mem (
    .clk       (clk),
    .rst       (rst),
    .load_v    (load_v),
    .load_data (load_data),
    .raddr_a   (raddr_a),
    .raddr_b   (raddr_b),
    .rden      (rden),
    .rd_v      (rd_v),
    .rd_addr   (rd_addr),
    .wb_v      (wb_v),     // Results loop back into memory
    .wb_addr   (wb_addr),
    .wb_data   (wb_data),
    .dout_a    (dout_a),
    .dout_b    (dout_b),
    .rd_data   (rd_data),
    .rd_data_v (rd_data_v)
  );

  cpx_alu #(
    .MUL_SHIFT (MUL_SHIFT)
  ) u_alu (
    .clk     (clk),
    .rst     (rst),
    .op_v    (op_v),
    .op      (op),
    .dst     (dst),
    .imm     (imm),
    .src_a   (dout_a),
    .src_b   (dout_b),
    .wb_v    (wb_v),
    .wb_addr (wb_addr),
    .wb_data (wb_data)
  );

endmodule

`default_nettype wire

// File: test/tb_cpx_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cpx_core;

  import cpx_pkg::*;

  localparam int MUL_SHIFT   = 15;
  localparam int SEED        = 53;
  localparam int N_WORDS     = 16;  // Full load burst
  localparam int N_TESTS     = 17;
  localparam int MAX_GAP     = 6;   // Widest issue spacing in the table
  localparam int WB_LAT      = 4;   // inst_v to wb_v
  localparam int RD_RESP_LAT = 3;   // rd_v to rd_data_v
  localparam int TIMEOUT_CYC = N_TESTS * MAX_GAP + 8 * N_WORDS + 100;

  typedef struct packed {
    opcode_e    op;
    logic [7:0] f1;   // src1, or imm_re for SET
    logic [7:0] f2;   // src2, or imm_im for SET
    logic [7:0] dst;
    logic [3:0] gap;  // Cycles to the next issue
  } test_t;

  typedef struct packed {
    int                cyc;   // Cycle of the request
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } exp_t;

  logic              clk;
  logic              rst;
  logic              load_v;
  logic [DATA_W-1:0] load_data;
  logic              inst_v;
  inst_u             inst;
  logic              rd_v;
  logic [ADDR_W-1:0] rd_addr;
  logic              rd_data_v;
  logic [DATA_W-1:0] rd_data;
  logic              wb_v;
  logic [ADDR_W-1:0] wb_addr;
  logic [DATA_W-1:0] wb_data;

  logic [DATA_W-1:0] ref_mem [MEM_DEPTH]; // Reference memory model
  bit                written [MEM_DEPTH];
  exp_t              wb_q [$];            // Outstanding write-backs
  exp_t              rd_q [$];            // Outstanding readbacks
  int                cyc = 0;
  int                n_pass = 0;
  int                n_fail = 0;

  test_t tbl [N_TESTS] = '{
    '{OP_ADD, 8'd0,  8'd1,  8'd32, 4'd6},
    '{OP_SUB, 8'd2,  8'd3,  8'd33, 4'd6},
    '{OP_SET, 8'hfd, 8'h05, 8'd34, 4'd6},  // -3 + 5i
    '{OP_SET, 8'h80, 8'hff, 8'd35, 4'd6},  // Both halves negative
    '{OP_SUB, 8'd4,  8'd4,  8'd36, 4'd6},  // Zero
    '{OP_MUL, 8'd5,  8'd6,  8'd40, 4'd6},
    '{OP_MUL, 8'd14, 8'd14, 8'd41, 4'd6},  // -1 * -1 wraps
    '{OP_MUL, 8'd7,  8'd15, 8'd42, 4'd6},  // Times zero
    '{OP_MUL, 8'd8,  8'd14, 8'd43, 4'd6},
    '{OP_ADD, 8'd32, 8'd33, 8'd48, 4'd6},  // Chain starts
    '{OP_ADD, 8'd48, 8'd0,  8'd49, 4'd6},
    '{OP_MUL, 8'd49, 8'd34, 8'd50, 4'd6},
    '{OP_SUB, 8'd50, 8'd49, 8'd48, 4'd6},  // Overwrites 48
    '{OP_ADD, 8'd9,  8'd10, 8'd56, 4'd1},  // Four in a row
    '{OP_SUB, 8'd11, 8'd12, 8'd57, 4'd1},
    '{OP_MUL, 8'd13, 8'd9,  8'd58, 4'd1},
    '{OP_SET, 8'h07, 8'hf9, 8'd59, 4'd6}
  };

  cpx_core #(
    .MUL_SHIFT (MUL_SHIFT)
  ) dut_i (
    .clk       (clk),
    .rst       (rst),
    .load_v    (load_v),
    .load_data (load_data),
    .inst_v    (inst_v),
    .inst      (inst),
    .rd_v      (rd_v),
    .rd_addr   (rd_addr),
    .rd_data_v (rd_data_v),
    .rd_data   (rd_data),
    .wb_v      (wb_v),
    .wb_addr   (wb_addr),
    .wb_data   (wb_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // Cycle count, read on rising edges where it is stable
  always @(negedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT_CYC) begin
      $display("Timeout: run still going after %0d cycles", cyc);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  function automatic logic [DATA_W-1:0] golden(opcode_e op, logic [DATA_W-1:0] a,
                                               logic [DATA_W-1:0] b,
                                               logic [7:0] re8, logic [7:0] im8);
    logic signed [HALF_W-1:0] ar, ai, br, bi;
    logic [HALF_W-1:0]        sr, si;
    longint                   pr, pi;
    ar = a[31:16];
    ai = a[15:0];
    br = b[31:16];
    bi = b[15:0];
    sr = '0;
    si = '0;
    case (op)
      OP_ADD: begin
        sr = ar + br; // Wraps at 16 bits
        si = ai + bi;
      end
      OP_SUB: begin
        sr = ar - br;
        si = ai - bi;
      end
      OP_MUL: begin
        pr = (longint'(ar) * longint'(br) - longint'(ai) * longint'(bi)) >>> MUL_SHIFT;
        pi = (longint'(ar) * longint'(bi) + longint'(ai) * longint'(br)) >>> MUL_SHIFT;
        sr = pr[HALF_W-1:0]; // Keep low half only
        si = pi[HALF_W-1:0];
      end
      OP_SET: begin
        sr = {{8{re8[7]}}, re8};
        si = {{8{im8[7]}}, im8};
      end
      default: ;
    endcase
    return {sr, si};
  endfunction

  function automatic void log_result(bit ok, string what);
    if (ok) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("%s %s", ok ? "ok    " : "FAILED", what);
  endfunction

  // One strobe against the oldest outstanding request
  function automatic void check_strobe(string kind, bit have, exp_t e, bit has_addr,
                                       logic [ADDR_W-1:0] addr, logic [DATA_W-1:0] data,
                                       int lat);
    bit ok;
    assert (have) else $display("Unexpected %s strobe at %0t", kind, $time);
    ok = have && (!has_addr || addr == e.addr) && data == e.data && cyc - e.cyc == lat;
    if (have) begin
      assert (ok) else begin
        $display("** Error @%0t: %s got %0d:%h after %0d cycles, want %0d:%h after %0d",
                 $time, kind, addr, data, cyc - e.cyc, e.addr, e.data, lat);
      end
    end
    log_result(ok, $sformatf("%s %0d = %h", kind, addr, data));
  endfunction

  always @(negedge clk) begin
    exp_t e;
    bit   have;
    if (wb_v) begin
      have = wb_q.size() != 0;
      e    = '0;
      if (have) begin
        e = wb_q.pop_front();
      end
      check_strobe("write-back", have, e, 1'b1, wb_addr, wb_data, WB_LAT);
    end
    if (rd_data_v) begin
      have = rd_q.size() != 0;
      e    = '0;
      if (have) begin
        e = rd_q.pop_front();
      end
      check_strobe("readback", have, e, 1'b0, e.addr, rd_data, RD_RESP_LAT); // No address out
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Every burst writes from address 0
  task automatic load_burst(int n, bit special);
    logic [DATA_W-1:0] w;
    for (int i = 0; i < n; i++) begin
      w = $urandom;
      if (special && i >= N_WORDS - 2) begin
        w = (i == N_WORDS - 2) ? 32'h8000_0000 : '0; // -1 + 0i, then zero
      end
      @(posedge clk);
      load_v     <= 1'b1;
      load_data  <= w;
      ref_mem[i] = w;
      written[i] = 1'b1;
    end
    @(posedge clk);
    load_v <= 1'b0;
  endtask

  // Back-to-back reads of every written address in the range
  task automatic read_back(int lo, int hi);
    exp_t e;
    for (int a = lo; a <= hi; a++) begin
      if (written[a]) begin
        @(posedge clk);
        rd_v    <= 1'b1;
        rd_addr <= ADDR_W'(a);
        e.cyc  = cyc;
        e.addr = ADDR_W'(a);
        e.data = ref_mem[a];
        rd_q.push_back(e);
      end
    end
    @(posedge clk);
    rd_v <= 1'b0;
  endtask

  task automatic issue(test_t t);
    inst_u w;
    exp_t  e;
    w = '0;
    if (t.op == OP_SET) begin
      w.imm.opcode = t.op;
      w.imm.imm_re = t.f1;
      w.imm.imm_im = t.f2;
      w.imm.dst    = t.dst;
    end else begin
      w.alu.opcode = t.op;
      w.alu.src1   = t.f1;
      w.alu.src2   = t.f2;
      w.alu.dst    = t.dst;
    end
    @(posedge clk);
    inst_v <= 1'b1;
    inst   <= w;
    e.cyc  = cyc;
    e.addr = t.dst;
    e.data = golden(t.op, ref_mem[t.f1], ref_mem[t.f2], t.f1, t.f2);
    wb_q.push_back(e);
    ref_mem[t.dst] = e.data; // Table spacing keeps readers 6 cycles behind
    written[t.dst] = 1'b1;
    repeat (t.gap - 1) begin
      @(posedge clk);
      inst_v <= 1'b0;
    end
  endtask

  initial begin
    int n;
    bit ok;
    void'($urandom(SEED));
    rst       = 1'b1;
    load_v    = 1'b0;
    load_data = '0;
    inst_v    = 1'b0;
    inst      = '0;
    rd_v      = 1'b0;
    rd_addr   = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    load_burst(N_WORDS, 1'b0);
    read_back(0, N_WORDS - 1);
    load_burst(N_WORDS / 2, 1'b0);  // Short burst, one idle cycle, full burst
    load_burst(N_WORDS, 1'b1);
    read_back(0, N_WORDS - 1);

    foreach (tbl[i]) begin
      issue(tbl[i]);
    end
    read_back(32, 63);              // Results land in memory

    // Wait for the last strobes, then a little longer for strays
    n = 0;
    while ((wb_q.size() != 0 || rd_q.size() != 0) && n < 4 * MAX_GAP) begin
      @(posedge clk);
      n++;
    end
    repeat (MAX_GAP) @(posedge clk);
    ok = wb_q.size() == 0 && rd_q.size() == 0;
    assert (ok) else begin
      $display("%0d write-backs and %0d reads were never answered",
               wb_q.size(), rd_q.size());
    end
    if (!ok) begin
      n_fail++;
    end

    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/cpx_pkg.sv
src/sdp_bram.sv
src/inst_decoder.sv
src/data_mem.sv
src/cpx_alu.sv
src/cpx_core.sv
test/tb_cpx_core.sv

// File: Makefile
# Verilator build and run of the complex arithmetic core testbench

VERILATOR ?= verilator
TOP       ?= tb_cpx_core
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ns

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
